// File: all.f
+incdir+common
common/exu_pkg.sv
common/exu_issue_if.sv
design/exu_alu.sv
design/branch_unit.sv
csr/csr_update.sv
csr/csr_file.sv
design/exu_stage.sv
design/exu_top.sv
test/tb_exu_top.sv

// File: common/exu_issue_if.sv
`include "exu_macros.svh"

interface exu_issue_if;
  import exu_pkg::*;

  logic [6:0]       opcode;
  alu_op_e          alu_op;
  imm_u             imm;
  logic [`XLEN-1:0] src1;
  logic [`XLEN-1:0] src2;
  logic [`XLEN-1:0] pc;
  // op_j + imm latched at issue
  logic [`XLEN-1:0] target;

  modport issue (
    output opcode, alu_op, imm, src1, src2, pc, target
  );

  modport exec (
    input opcode, alu_op, imm, src1, src2, pc, target
  );

endinterface

// File: common/exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// datapath width
`define XLEN 64

// major opcodes, instruction bits 6:0
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_SYSTEM 7'b1110011
`define OP_ALU    7'b0110011

// system function codes in imm[3:0]
`define SYS_PRIV   4'h0
`define SYS_CSRRW  4'h1
`define SYS_CSRRS  4'h2
`define SYS_CSRRC  4'h3
`define SYS_CSRRWI 4'h5
`define SYS_CSRRSI 4'h6
`define SYS_CSRRCI 4'h7

// privileged codes in imm[15:4] when funct is SYS_PRIV
`define SYS_ECALL  12'h000
`define SYS_EBREAK 12'h001
`define SYS_MRET   12'h302

// machine csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// environment call from M-mode
`define MCAUSE_ECALL_M `XLEN'(11)

`endif

// File: common/exu_pkg.sv
`include "exu_macros.svh"

package exu_pkg;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_SGE, ALU_SGEU
  } alu_op_e;

  // system view of the immediate word
  typedef struct packed {
    logic [`XLEN-17:0] upper;
    logic [11:0]       csr_addr;
    logic [3:0]        funct;
  } sys_imm_t;

  typedef union packed {
    logic [`XLEN-1:0] word;
    sys_imm_t         sys;
  } imm_u;

endpackage

// File: csr/csr_file.sv
`include "exu_macros.svh"

module csr_file (
  input  logic             clk,
  input  logic             rst,
  input  logic [11:0]      csr_addr_i,
  input  logic             csr_wen_i,
  input  logic [`XLEN-1:0] csr_wdata_i,
  input  logic             ecall_wen_i,
  input  logic [`XLEN-1:0] ecall_pc_i,
  output logic [`XLEN-1:0] csr_rdata_o,
  output logic [`XLEN-1:0] mtvec_o,
  output logic [`XLEN-1:0] mepc_o
);

  logic [`XLEN-1:0] mstatus, mtvec, mepc, mcause;

  always_comb begin
    case (csr_addr_i)
      `CSR_MSTATUS: csr_rdata_o = mstatus;
      `CSR_MTVEC:   csr_rdata_o = mtvec;
      `CSR_MEPC:    csr_rdata_o = mepc;
      `CSR_MCAUSE:  csr_rdata_o = mcause;
      default:      csr_rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (csr_wen_i) begin
        case (csr_addr_i)
          `CSR_MSTATUS: mstatus <= csr_wdata_i;
          `CSR_MTVEC:   mtvec   <= csr_wdata_i;
          `CSR_MEPC:    mepc    <= csr_wdata_i;
          `CSR_MCAUSE:  mcause  <= csr_wdata_i;
          default: ;
        endcase
      end
      // second write port for the ecall pc
      if (ecall_wen_i) mepc <= ecall_pc_i;
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

  a_ecall_pairs_mcause: assert property (@(posedge clk) disable iff (rst)
    ecall_wen_i |-> (csr_wen_i && csr_addr_i == `CSR_MCAUSE));

endmodule

// File: csr/csr_update.sv
`include "exu_macros.svh"

module csr_update (
  exu_issue_if.exec        issue_if,
  input  logic [`XLEN-1:0] csr_rdata_i,
  input  logic             commit_i,
  output logic [11:0]      csr_addr_o,
  output logic             csr_wen_o,
  output logic [`XLEN-1:0] csr_wdata_o,
  output logic             ecall_wen_o,
  output logic [`XLEN-1:0] ecall_pc_o
);

  logic       is_sys, is_priv, is_ecall, is_mret, is_csr_op;
  logic [3:0] funct;

  assign is_sys   = issue_if.opcode == `OP_SYSTEM;
  assign funct    = issue_if.imm.sys.funct;
  assign is_priv  = is_sys && funct == `SYS_PRIV;
  assign is_ecall = is_priv && issue_if.imm.sys.csr_addr == `SYS_ECALL;
  assign is_mret  = is_priv && issue_if.imm.sys.csr_addr == `SYS_MRET;

  assign csr_addr_o = is_ecall ? `CSR_MCAUSE :
                      is_mret  ? `CSR_MSTATUS : issue_if.imm.sys.csr_addr;

  // immediate forms arrive already zero-extended in src1
  always_comb begin
    is_csr_op   = 1'b1;
    csr_wdata_o = issue_if.src1;
    case (funct)
      `SYS_CSRRW, `SYS_CSRRWI: csr_wdata_o = issue_if.src1;
      `SYS_CSRRS, `SYS_CSRRSI: csr_wdata_o = csr_rdata_i | issue_if.src1;
      `SYS_CSRRC, `SYS_CSRRCI: csr_wdata_o = csr_rdata_i & ~issue_if.src1;
      default:                 is_csr_op = 1'b0;
    endcase
    if (is_ecall) begin
      csr_wdata_o = `MCAUSE_ECALL_M;
    end else if (is_mret) begin
      // MPIE set, MIE takes the old MPIE
      csr_wdata_o = {csr_rdata_i[`XLEN-1:8], 1'b1, csr_rdata_i[6:4],
                     csr_rdata_i[7], csr_rdata_i[2:0]};
    end
  end

  // writes only on the consuming cycle
  assign csr_wen_o   = commit_i && is_sys && (is_ecall || is_mret || is_csr_op);
  assign ecall_wen_o = commit_i && is_ecall;
  assign ecall_pc_o  = issue_if.pc;

endmodule

// File: design/branch_unit.sv
`include "exu_macros.svh"

module branch_unit (
  exu_issue_if.exec        issue_if,
  input  logic [`XLEN-1:0] alu_res_i,
  input  logic [`XLEN-1:0] mtvec_i,
  input  logic [`XLEN-1:0] mepc_i,
  output logic [`XLEN-1:0] npc_o,
  output logic             use_npc_o,
  output logic             ebreak_o
);
  import exu_pkg::*;

  always_comb begin
    npc_o     = issue_if.target;
    use_npc_o = 1'b0;
    ebreak_o  = 1'b0;
    case (issue_if.opcode)
      `OP_JAL, `OP_JALR: use_npc_o = 1'b1;
      `OP_BRANCH: begin
        case (issue_if.alu_op)
          // beq
          ALU_SUB: use_npc_o = ~|alu_res_i;
          ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SGE, ALU_SGEU: use_npc_o = |alu_res_i;
          default: use_npc_o = 1'b0;
        endcase
      end
      `OP_SYSTEM: begin
        if (issue_if.imm.sys.funct == `SYS_PRIV) begin
          case (issue_if.imm.sys.csr_addr)
            `SYS_ECALL: begin
              use_npc_o = 1'b1;
              npc_o     = mtvec_i;
            end
            `SYS_MRET: begin
              use_npc_o = 1'b1;
              npc_o     = mepc_i;
            end
            `SYS_EBREAK: begin
              use_npc_o = 1'b1;
              ebreak_o  = 1'b1;
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

endmodule

// File: design/exu_alu.sv
`include "exu_macros.svh"

module exu_alu (
  exu_issue_if.exec        issue_if,
  output logic [`XLEN-1:0] alu_res_o
);
  import exu_pkg::*;

  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [5:0]       shamt;

  assign a     = issue_if.src1;
  assign b     = issue_if.src2;
  assign shamt = b[5:0];

  always_comb begin
    case (issue_if.alu_op)
      ALU_ADD:  alu_res_o = a + b;
      ALU_SUB:  alu_res_o = a - b;
      ALU_AND:  alu_res_o = a & b;
      ALU_OR:   alu_res_o = a | b;
      ALU_XOR:  alu_res_o = a ^ b;
      ALU_SLL:  alu_res_o = a << shamt;
      ALU_SRL:  alu_res_o = a >> shamt;
      ALU_SRA:  alu_res_o = $signed(a) >>> shamt;
      // compares give 0 or 1
      ALU_SLT:  alu_res_o = `XLEN'($signed(a) < $signed(b));
      ALU_SLTU: alu_res_o = `XLEN'(a < b);
      ALU_SGE:  alu_res_o = `XLEN'($signed(a) >= $signed(b));
      ALU_SGEU: alu_res_o = `XLEN'(a >= b);
      default:  alu_res_o = '0;
    endcase
  end

endmodule

// File: design/exu_stage.sv
`include "exu_macros.svh"

module exu_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              prev_valid_i,
  input  logic              next_ready_i,
  input  logic              ren_i,
  input  logic              wen_i,
  input  logic              rwen_i,
  input  logic [4:0]        rd_i,
  input  logic [`XLEN-1:0]  imm_i,
  input  logic [`XLEN-1:0]  op1_i,
  input  logic [`XLEN-1:0]  op2_i,
  input  logic [`XLEN-1:0]  op_j_i,
  input  logic [`XLEN-1:0]  pc_i,
  input  exu_pkg::alu_op_e  alu_op_i,
  input  logic [6:0]        opcode_i,
  input  logic [`XLEN-1:0]  mem_rdata_i,
  input  logic              mem_rvalid_i,
  input  logic              mem_wready_i,
  input  logic [`XLEN-1:0]  alu_res_i,
  input  logic [`XLEN-1:0]  csr_rdata_i,
  output logic              valid_o,
  output logic              ready_o,
  output logic              lsu_avalid_o,
  output logic              mem_ren_o,
  output logic              mem_wen_o,
  output logic [`XLEN-1:0]  mem_addr_o,
  output logic [`XLEN-1:0]  mem_wdata_o,
  output logic [4:0]        rd_o,
  output logic              rwen_o,
  output logic [`XLEN-1:0]  reg_wdata_o,
  output logic              commit_o,
  exu_issue_if.issue        issue_if
);

  logic             accept, consume, mem_resp;
  logic             alu_valid_q, busy_q, resp_q;
  logic [`XLEN-1:0] mem_rdata_q;

  assign accept   = prev_valid_i && ready_o;
  assign consume  = valid_o && next_ready_i;
  assign mem_resp = lsu_avalid_o &&
                    ((mem_ren_o && mem_rvalid_i) || (mem_wen_o && mem_wready_i));

  // busy covers a memory op from issue until its result is taken
  assign valid_o      = alu_valid_q || resp_q;
  assign ready_o      = !busy_q && (!valid_o || next_ready_i);
  assign lsu_avalid_o = busy_q && !resp_q;
  assign commit_o     = consume;

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid_q <= 1'b0;
      busy_q      <= 1'b0;
      resp_q      <= 1'b0;
      mem_ren_o   <= 1'b0;
      mem_wen_o   <= 1'b0;
      rwen_o      <= 1'b0;
    end else if (accept) begin
      alu_valid_q <= !(ren_i || wen_i);
      busy_q      <= ren_i || wen_i;
      resp_q      <= 1'b0;
      mem_ren_o   <= ren_i;
      mem_wen_o   <= wen_i;
      rwen_o      <= rwen_i;
    end else begin
      if (consume) begin
        alu_valid_q <= 1'b0;
        busy_q      <= 1'b0;
        resp_q      <= 1'b0;
      end
      if (mem_resp) resp_q <= 1'b1;
    end
  end

  // issue register
  always_ff @(posedge clk) begin
    if (accept) begin
      issue_if.opcode   <= opcode_i;
      issue_if.alu_op   <= alu_op_i;
      issue_if.imm.word <= imm_i;
      issue_if.src1     <= op1_i;
      issue_if.src2     <= op2_i;
      issue_if.pc       <= pc_i;
      issue_if.target   <= op_j_i + imm_i;
      rd_o              <= rd_i;
    end
    if (mem_resp && mem_ren_o) mem_rdata_q <= mem_rdata_i;
  end

  assign mem_addr_o  = issue_if.target;
  assign mem_wdata_o = issue_if.src2;

  assign reg_wdata_o = (issue_if.opcode == `OP_LOAD)   ? mem_rdata_q :
                       (issue_if.opcode == `OP_SYSTEM) ? csr_rdata_i : alu_res_i;

  a_avalid_has_dir: assert property (@(posedge clk) disable iff (rst)
    lsu_avalid_o |-> (mem_ren_o || mem_wen_o));

  a_no_ready_in_flight: assert property (@(posedge clk) disable iff (rst)
    lsu_avalid_o |=> !ready_o);

endmodule

// File: design/exu_top.sv
`include "exu_macros.svh"

module exu_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              prev_valid_i,
  input  logic              next_ready_i,
  input  logic              ren_i,
  input  logic              wen_i,
  input  logic              rwen_i,
  input  logic [4:0]        rd_i,
  input  logic [`XLEN-1:0]  imm_i,
  input  logic [`XLEN-1:0]  op1_i,
  input  logic [`XLEN-1:0]  op2_i,
  input  logic [`XLEN-1:0]  op_j_i,
  input  logic [`XLEN-1:0]  pc_i,
  input  exu_pkg::alu_op_e  alu_op_i,
  input  logic [6:0]        opcode_i,
  input  logic [`XLEN-1:0]  mem_rdata_i,
  input  logic              mem_rvalid_i,
  input  logic              mem_wready_i,
  output logic              valid_o,
  output logic              ready_o,
  output logic              lsu_avalid_o,
  output logic              mem_ren_o,
  output logic              mem_wen_o,
  output logic [`XLEN-1:0]  mem_addr_o,
  output logic [`XLEN-1:0]  mem_wdata_o,
  output logic [4:0]        rd_o,
  output logic              rwen_o,
  output logic [`XLEN-1:0]  reg_wdata_o,
  output logic              commit_o,
  output logic [`XLEN-1:0]  npc_o,
  output logic              use_npc_o,
  output logic              ebreak_o
);

  logic [`XLEN-1:0] alu_res, csr_rdata, csr_wdata, ecall_pc, mtvec, mepc;
  logic [11:0]      csr_addr;
  logic             csr_wen, ecall_wen;

  exu_issue_if issue_if ();

  exu_stage i_exu_stage (
    .clk, .rst, .prev_valid_i, .next_ready_i, .ren_i, .wen_i, .rwen_i, .rd_i,
    .imm_i, .op1_i, .op2_i, .op_j_i, .pc_i, .alu_op_i, .opcode_i,
    .mem_rdata_i, .mem_rvalid_i, .mem_wready_i,
    .alu_res_i(alu_res), .csr_rdata_i(csr_rdata),
    .valid_o, .ready_o, .lsu_avalid_o, .mem_ren_o, .mem_wen_o, .mem_addr_o,
    .mem_wdata_o, .rd_o, .rwen_o, .reg_wdata_o, .commit_o,
    .issue_if(issue_if.issue)
  );

  exu_alu i_exu_alu (.issue_if(issue_if.exec), .alu_res_o(alu_res));

  branch_unit i_branch_unit (
    .issue_if(issue_if.exec), .alu_res_i(alu_res), .mtvec_i(mtvec), .mepc_i(mepc),
    .npc_o, .use_npc_o, .ebreak_o
  );

  csr_update i_csr_update (
    .issue_if(issue_if.exec), .csr_rdata_i(csr_rdata), .commit_i(commit_o),
    .csr_addr_o(csr_addr), .csr_wen_o(csr_wen), .csr_wdata_o(csr_wdata),
    .ecall_wen_o(ecall_wen), .ecall_pc_o(ecall_pc)
  );

  csr_file i_csr_file (
    .clk, .rst, .csr_addr_i(csr_addr), .csr_wen_i(csr_wen), .csr_wdata_i(csr_wdata),
    .ecall_wen_i(ecall_wen), .ecall_pc_i(ecall_pc),
    .csr_rdata_o(csr_rdata), .mtvec_o(mtvec), .mepc_o(mepc)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds and runs the exu testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f all.f --top-module tb_exu_top \
  -Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed$" sim.log; then
  exit 0
fi
exit 1

// File: test/tb_exu_top.sv
`include "exu_macros.svh"

module tb_exu_top;
  timeunit 1ns;
  timeprecision 1ps;

  import exu_pkg::*;

  logic             clk = 1'b0;
  logic             rst;
  logic             prev_valid_i, next_ready_i, ren_i, wen_i, rwen_i;
  logic [4:0]       rd_i;
  logic [`XLEN-1:0] imm_i, op1_i, op2_i, op_j_i, pc_i;
  alu_op_e          alu_op_i;
  logic [6:0]       opcode_i;
  logic [`XLEN-1:0] mem_rdata_i = '0;
  logic             mem_rvalid_i = 1'b0;
  logic             mem_wready_i = 1'b0;
  logic             valid_o, ready_o, lsu_avalid_o, mem_ren_o, mem_wen_o;
  logic [`XLEN-1:0] mem_addr_o, mem_wdata_o, reg_wdata_o, npc_o;
  logic [4:0]       rd_o;
  logic             rwen_o, commit_o, use_npc_o, ebreak_o;

  int               errors = 0;
  int               n_issued = 0;
  int               cycles = 0;
  int               mem_wait = -1;
  string            test_name = "reset";
  logic             chk_wdata = 1'b0, chk_npc = 1'b0, exp_use_npc = 1'b0, exp_ebreak = 1'b0;
  logic [`XLEN-1:0] exp_wdata = '0, exp_npc = '0;
  logic [4:0]       exp_rd = '0;
  logic             exp_rwen = 1'b0;
  logic             exp_store = 1'b0;
  logic [`XLEN-1:0] exp_addr = '0;
  logic             mem_pending = 1'b0;
  logic             stall_q = 1'b0;
  logic [`XLEN-1:0] wdata_q, npc_q;
  logic [`XLEN-1:0] mem_model [logic [`XLEN-1:0]];
  alu_op_e          br_ops [6] = '{ALU_SUB, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SGE, ALU_SGEU};

  exu_top i_exu_top (.*);

  always #10 clk = ~clk;

  // memory responder with 0 to 5 cycles of latency
  always @(negedge clk) begin
    mem_rvalid_i = 1'b0;
    mem_wready_i = 1'b0;
    if (lsu_avalid_o) begin
      if (mem_wait < 0) mem_wait = $urandom % 6;
      if (mem_wait == 0) begin
        if (mem_wen_o) begin
          mem_model[mem_addr_o] = mem_wdata_o;
          mem_wready_i = 1'b1;
        end else begin
          mem_rdata_i  = mem_model.exists(mem_addr_o) ? mem_model[mem_addr_o] : '0;
          mem_rvalid_i = 1'b1;
        end
        mem_wait = -1;
      end else begin
        mem_wait--;
      end
    end
  end

  always @(posedge clk) begin
    stall_q <= valid_o && !next_ready_i;
    wdata_q <= reg_wdata_o;
    npc_q   <= npc_o;
  end

  initial begin
    while (cycles <= 200 * (n_issued + 1) + 16) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no result after %0d cycles, %0d instructions issued", cycles, n_issued);
    $display("Some tests failed");
    $finish;
  end

  a_result: assert property (@(posedge clk) disable iff (rst)
    (valid_o && chk_wdata) |-> reg_wdata_o == exp_wdata)
    else begin
      errors++;
      $display("FAILED %s reg_wdata_o: expected %h, actual %h", test_name,
               $sampled(exp_wdata), $sampled(reg_wdata_o));
    end

  a_npc: assert property (@(posedge clk) disable iff (rst)
    (valid_o && chk_npc) |-> npc_o == exp_npc)
    else begin
      errors++;
      $display("FAILED %s npc_o: expected %h, actual %h", test_name,
               $sampled(exp_npc), $sampled(npc_o));
    end

  a_use_npc: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> use_npc_o == exp_use_npc)
    else begin
      errors++;
      $display("FAILED %s use_npc_o: expected %b, actual %b", test_name,
               $sampled(exp_use_npc), $sampled(use_npc_o));
    end

  a_ebreak: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> ebreak_o == exp_ebreak)
    else begin
      errors++;
      $display("FAILED %s ebreak_o: expected %b, actual %b", test_name,
               $sampled(exp_ebreak), $sampled(ebreak_o));
    end

  a_dest: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> (rd_o == exp_rd && rwen_o == exp_rwen))
    else begin
      errors++;
      $display("FAILED %s rd_o/rwen_o: expected %h/%b, actual %h/%b", test_name,
               $sampled(exp_rd), $sampled(exp_rwen), $sampled(rd_o), $sampled(rwen_o));
    end

  a_commit: assert property (@(posedge clk) disable iff (rst)
    commit_o == (valid_o && next_ready_i))
    else begin
      errors++;
      $display("FAILED %s commit_o: expected %b, actual %b", test_name,
               $sampled(valid_o && next_ready_i), $sampled(commit_o));
    end

  a_mem_req: assert property (@(posedge clk) disable iff (rst)
    lsu_avalid_o |-> (mem_addr_o == exp_addr && mem_wen_o == exp_store &&
                      mem_ren_o == !exp_store))
    else begin
      errors++;
      $display("FAILED %s memory request: expected %h wen %b, actual %h wen %b ren %b",
               test_name, $sampled(exp_addr), $sampled(exp_store), $sampled(mem_addr_o),
               $sampled(mem_wen_o), $sampled(mem_ren_o));
    end

  a_mem_ready: assert property (@(posedge clk) disable iff (rst)
    mem_pending |-> !ready_o)
    else begin
      errors++;
      $display("error in %s: ready_o was high while a memory access was open", test_name);
    end

  a_hold_valid: assert property (@(posedge clk) disable iff (rst)
    stall_q |-> valid_o)
    else begin
      errors++;
      $display("error in %s: valid_o dropped while next_ready_i was low", test_name);
    end

  a_hold_wdata: assert property (@(posedge clk) disable iff (rst)
    stall_q |-> reg_wdata_o == wdata_q)
    else begin
      errors++;
      $display("FAILED %s held reg_wdata_o: expected %h, actual %h", test_name,
               $sampled(wdata_q), $sampled(reg_wdata_o));
    end

  a_hold_npc: assert property (@(posedge clk) disable iff (rst)
    stall_q |-> npc_o == npc_q)
    else begin
      errors++;
      $display("FAILED %s held npc_o: expected %h, actual %h", test_name,
               $sampled(npc_q), $sampled(npc_o));
    end

  function automatic logic [`XLEN-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [`XLEN-1:0] alu_model(input alu_op_e op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    logic signed [`XLEN-1:0] sa;
    logic signed [`XLEN-1:0] sb;
    sa = a;
    sb = b;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[5:0];
      ALU_SRL:  return a >> b[5:0];
      ALU_SRA:  return sa >>> b[5:0];
      ALU_SLT:  return {63'b0, sa < sb};
      ALU_SLTU: return {63'b0, a < b};
      ALU_SGE:  return {63'b0, sa >= sb};
      ALU_SGEU: return {63'b0, a >= b};
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_taken(input alu_op_e op, input logic [`XLEN-1:0] a,
                                        input logic [`XLEN-1:0] b);
    case (op)
      ALU_SUB:  return a == b;
      ALU_XOR:  return a != b;
      ALU_SLT:  return $signed(a) < $signed(b);
      ALU_SLTU: return a < b;
      ALU_SGE:  return $signed(a) >= $signed(b);
      ALU_SGEU: return a >= b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] sys_imm(input logic [11:0] addr, input logic [3:0] funct);
    imm_u u;
    u.word         = '0;
    u.sys.csr_addr = addr;
    u.sys.funct    = funct;
    return u.word;
  endfunction

  task automatic set_expect(input logic cw, input logic [`XLEN-1:0] w, input logic cn,
                            input logic [`XLEN-1:0] n, input logic un, input logic eb);
    chk_wdata   = cw;
    exp_wdata   = w;
    chk_npc     = cn;
    exp_npc     = n;
    exp_use_npc = un;
    exp_ebreak  = eb;
  endtask

  // one instruction, returns on the negedge after its result is taken
  task automatic run_instr(input logic [6:0] opc, input alu_op_e op,
                           input logic [`XLEN-1:0] imm, input logic [`XLEN-1:0] a,
                           input logic [`XLEN-1:0] b, input logic [`XLEN-1:0] opj,
                           input logic [`XLEN-1:0] pc, input logic is_load,
                           input logic is_store, input int stall);
    int   left;
    logic done;
    left = stall;
    done = 1'b0;
    while (!ready_o) @(negedge clk);
    exp_rd       = 5'($urandom);
    exp_rwen     = 1'($urandom);
    exp_store    = is_store;
    opcode_i     = opc;
    alu_op_i     = op;
    imm_i        = imm;
    op1_i        = a;
    op2_i        = b;
    op_j_i       = opj;
    pc_i         = pc;
    ren_i        = is_load;
    wen_i        = is_store;
    rwen_i       = exp_rwen;
    rd_i         = exp_rd;
    prev_valid_i = 1'b1;
    n_issued++;
    @(negedge clk);
    prev_valid_i = 1'b0;
    ren_i        = 1'b0;
    wen_i        = 1'b0;
    mem_pending  = is_load || is_store;
    while (!done) begin
      if (valid_o && left > 0) begin
        next_ready_i = 1'b0;
        left--;
      end else begin
        next_ready_i = ($urandom % 3) != 0;
      end
      done = valid_o && next_ready_i;
      @(negedge clk);
    end
    mem_pending  = 1'b0;
    next_ready_i = 1'b0;
  endtask

  task automatic csr_access(input logic [11:0] addr, input logic [3:0] funct,
                            input logic [`XLEN-1:0] src, input logic [`XLEN-1:0] old,
                            input int stall);
    set_expect(1'b1, old, 1'b0, '0, 1'b0, 1'b0);
    run_instr(`OP_SYSTEM, ALU_ADD, sys_imm(addr, funct), src, '0, '0, '0, 1'b0, 1'b0, stall);
  endtask

  initial begin
    logic [`XLEN-1:0] a, b, imm, opj, pc, addr, data;
    logic [`XLEN-1:0] m_mtvec, m_mstatus;
    alu_op_e          op;
    void'($urandom(86317));
    rst          = 1'b1;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    ren_i        = 1'b0;
    wen_i        = 1'b0;
    rwen_i       = 1'b0;
    rd_i         = '0;
    imm_i        = '0;
    op1_i        = '0;
    op2_i        = '0;
    op_j_i       = '0;
    pc_i         = '0;
    alu_op_i     = ALU_ADD;
    opcode_i     = '0;
    m_mtvec      = '0;
    m_mstatus    = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_name = "alu";
    for (int k = 0; k < 48; k++) begin
      op = alu_op_e'(4'(k % 12));
      a  = rand64();
      b  = (k % 5 == 0) ? a : rand64();
      set_expect(1'b1, alu_model(op, a, b), 1'b0, '0, 1'b0, 1'b0);
      run_instr(`OP_ALU, op, rand64(), a, b, rand64(), rand64(), 1'b0, 1'b0, 0);
    end

    test_name = "jump";
    for (int k = 0; k < 6; k++) begin
      imm = rand64();
      opj = rand64();
      set_expect(1'b0, '0, 1'b1, opj + imm, 1'b1, 1'b0);
      run_instr((k % 2 == 0) ? `OP_JAL : `OP_JALR, ALU_ADD, imm, rand64(), rand64(), opj,
                rand64(), 1'b0, 1'b0, 0);
    end

    test_name = "branch";
    for (int k = 0; k < 36; k++) begin
      op  = br_ops[k % 6];
      a   = rand64();
      b   = (k % 3 == 0) ? a : rand64();
      imm = rand64();
      opj = rand64();
      set_expect(1'b0, '0, 1'b1, opj + imm, branch_taken(op, a, b), 1'b0);
      run_instr(`OP_BRANCH, op, imm, a, b, opj, opj, 1'b0, 1'b0, 0);
    end

    test_name = "store_load";
    for (int k = 0; k < 8; k++) begin
      addr = rand64() & ~64'h7;
      data = rand64();
      imm  = {56'h0, 8'($urandom)};
      opj  = addr - imm;
      exp_addr = addr;
      set_expect(1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
      run_instr(`OP_STORE, ALU_ADD, imm, rand64(), data, opj, rand64(), 1'b0, 1'b1, 0);
      set_expect(1'b1, data, 1'b0, '0, 1'b0, 1'b0);
      run_instr(`OP_LOAD, ALU_ADD, imm, rand64(), rand64(), opj, rand64(), 1'b1, 1'b0, 0);
    end

    test_name = "csr_mtvec";
    a = rand64();
    csr_access(`CSR_MTVEC, `SYS_CSRRW, a, m_mtvec, 0);
    m_mtvec = a;
    a = rand64();
    csr_access(`CSR_MTVEC, `SYS_CSRRS, a, m_mtvec, 0);
    m_mtvec = m_mtvec | a;
    a = rand64();
    csr_access(`CSR_MTVEC, `SYS_CSRRC, a, m_mtvec, 0);
    m_mtvec = m_mtvec & ~a;
    csr_access(`CSR_MTVEC, `SYS_CSRRS, '0, m_mtvec, 0);

    test_name = "ecall_mret";
    pc = rand64() & ~64'h3;
    a  = rand64();
    a[7] = 1'b0;
    a[3] = 1'b1;
    csr_access(`CSR_MSTATUS, `SYS_CSRRW, a, m_mstatus, 0);
    m_mstatus = a;
    set_expect(1'b0, '0, 1'b1, m_mtvec, 1'b1, 1'b0);
    run_instr(`OP_SYSTEM, ALU_ADD, sys_imm(`SYS_ECALL, `SYS_PRIV), '0, '0, '0, pc,
              1'b0, 1'b0, 0);
    csr_access(`CSR_MEPC, `SYS_CSRRS, '0, pc, 0);
    csr_access(`CSR_MCAUSE, `SYS_CSRRS, '0, `MCAUSE_ECALL_M, 0);
    set_expect(1'b0, '0, 1'b1, pc, 1'b1, 1'b0);
    run_instr(`OP_SYSTEM, ALU_ADD, sys_imm(`SYS_MRET, `SYS_PRIV), '0, '0, '0, rand64(),
              1'b0, 1'b0, 0);
    // mpie set, mie gets the old mpie
    m_mstatus[3] = m_mstatus[7];
    m_mstatus[7] = 1'b1;
    csr_access(`CSR_MSTATUS, `SYS_CSRRS, '0, m_mstatus, 0);
    set_expect(1'b0, '0, 1'b0, '0, 1'b1, 1'b1);
    run_instr(`OP_SYSTEM, ALU_ADD, sys_imm(`SYS_EBREAK, `SYS_PRIV), '0, '0, '0, rand64(),
              1'b0, 1'b0, 0);

    test_name = "backpressure";
    a = rand64();
    b = rand64();
    set_expect(1'b1, alu_model(ALU_ADD, a, b), 1'b0, '0, 1'b0, 1'b0);
    run_instr(`OP_ALU, ALU_ADD, '0, a, b, '0, '0, 1'b0, 1'b0, 8);
    imm = rand64();
    opj = rand64();
    set_expect(1'b0, '0, 1'b1, opj + imm, 1'b1, 1'b0);
    run_instr(`OP_JAL, ALU_ADD, imm, '0, '0, opj, '0, 1'b0, 1'b0, 8);
    // a write during the stall would change the held csr read
    csr_access(`CSR_MCAUSE, `SYS_CSRRS, 64'h30, `MCAUSE_ECALL_M, 8);
    csr_access(`CSR_MCAUSE, `SYS_CSRRS, '0, `MCAUSE_ECALL_M | 64'h30, 0);

    repeat (2) @(negedge clk);
    $display("done: %0d instructions, %0d errors", n_issued, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
